/* spectrum_sound.f */
sound_pkg.sv
io_decode.sv
sound_regs.sv
audio_mixer.sv
spectrum_sound.sv
spectrum_sound_chk.sv
spectrum_sound_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sound path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  --top-module spectrum_sound_tb \
  -f spectrum_sound.f -o sim

./obj_dir/sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported errors"
  exit 1
fi

/* spectrum_sound_tb.sv */
`timescale 1ns/1ps

module spectrum_sound_tb;
  import sound_pkg::*;

  // same values as the mixer defaults
  localparam int beep_level = 4096;
  localparam int tape_level = 2048;
  // the tests take about 300 cycles
  localparam int max_cycles = 2000;

  logic     clk_28mhz = 1'b0;
  logic     rst;
  logic     iorq;
  logic     wr;
  io_addr_t addr;
  io_data_t data;
  logic     covox_en;
  logic     tape_in;
  logic     tape_out;
  sample_t  audio_l;
  sample_t  audio_r;

  int seed = 82;
  int errors = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int cycles = 0;

  // reference copy of #fe and the covox bytes a, b, c, d, fb
  io_data_t fe_m;
  io_data_t cvx_m [5];

  spectrum_sound #(
    .beep_level (beep_level),
    .tape_level (tape_level)
  ) uut (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .iorq      (iorq),
    .wr        (wr),
    .addr      (addr),
    .data      (data),
    .covox_en  (covox_en),
    .tape_in   (tape_in),
    .tape_out  (tape_out),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

  always #5 clk_28mhz = ~clk_28mhz;

  always @(posedge clk_28mhz) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  function automatic io_data_t rand_byte();
    return io_data_t'($random(seed));
  endfunction

  function automatic io_data_t cvx_port(input int i);
    case (i)
      0:       return port_cvx_a;
      1:       return port_cvx_b;
      2:       return port_cvx_c;
      3:       return port_cvx_d;
      default: return port_cvx_fb;
    endcase
  endfunction

  function automatic bit is_listed(input io_data_t port);
    return port inside {port_fe, port_cvx_a, port_cvx_b, port_cvx_c, port_cvx_d, port_cvx_fb};
  endfunction

  // covox bytes only land while the switch is on
  function automatic void apply_model(input io_data_t port, input io_data_t value);
    if (port == port_fe) begin
      fe_m = value;
    end else if (covox_en) begin
      case (port)
        port_cvx_a:  cvx_m[0] = value;
        port_cvx_b:  cvx_m[1] = value;
        port_cvx_c:  cvx_m[2] = value;
        port_cvx_d:  cvx_m[3] = value;
        port_cvx_fb: cvx_m[4] = value;
        default:     ;
      endcase
    end
  endfunction

  function automatic int exp_sample(input io_data_t x, input io_data_t y);
    int sum;
    sum = (int'(x) + int'(y) + int'(cvx_m[4])) << 5;
    if (fe_m[4]) sum += beep_level;
    if (tape_in) sum += tape_level;
    return sum;
  endfunction

  task automatic check_val(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("FAIL %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_samples();
    check_val("audio_l", exp_sample(cvx_m[0], cvx_m[1]), int'(audio_l));
    check_val("audio_r", exp_sample(cvx_m[2], cvx_m[3]), int'(audio_r));
  endtask

  // data is scrambled after the first edge, only that byte may count
  task automatic write_port(input io_data_t port, input io_data_t value, input int hold);
    @(posedge clk_28mhz);
    iorq <= 1'b1;
    wr   <= 1'b1;
    addr <= {rand_byte(), port};
    data <= value;
    repeat (hold) begin
      @(posedge clk_28mhz);
      data <= rand_byte();
    end
    iorq <= 1'b0;
    wr   <= 1'b0;
    @(posedge clk_28mhz);
  endtask

  task automatic write_random(input io_data_t port, input int hold);
    io_data_t v;
    v = rand_byte();
    write_port(port, v, hold);
    apply_model(port, v);
  endtask

  task automatic wait_result();
    repeat (3) @(posedge clk_28mhz);
    @(negedge clk_28mhz);
  endtask

  task automatic end_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, errors - start);
    end
  endtask

  task automatic reset_state();
    int start;
    start = errors;
    repeat (2) begin
      @(negedge clk_28mhz);
      check_val("tape_out", 0, int'(tape_out));
      check_val("audio_l", 0, int'(audio_l));
      check_val("audio_r", 0, int'(audio_r));
    end
    end_test("reset", start);
  endtask

  task automatic fe_port_writes();
    int start;
    start = errors;
    for (int i = 0; i < 8; i++) begin
      write_random(port_fe, 1);
      // back at E+1, tape_out moves at E+2 and the samples at E+3
      @(posedge clk_28mhz);
      @(negedge clk_28mhz);
      check_val("tape_out", int'(fe_m[3]), int'(tape_out));
      @(posedge clk_28mhz);
      @(negedge clk_28mhz);
      check_val("audio_l", fe_m[4] ? beep_level : 0, int'(audio_l));
      check_val("audio_r", fe_m[4] ? beep_level : 0, int'(audio_r));
    end
    end_test("fe_port", start);
  endtask

  task automatic covox_channels();
    int start;
    io_data_t v;
    start = errors;
    @(posedge clk_28mhz);
    covox_en <= 1'b1;
    for (int r = 0; r < 6; r++) begin
      for (int i = 0; i < 5; i++) begin
        write_random(cvx_port(i), 1);
      end
      v = rand_byte();
      v[4] = r[0];
      write_port(port_fe, v, 1);
      apply_model(port_fe, v);
      wait_result();
      check_samples();
    end
    end_test("covox", start);
  endtask

  task automatic covox_gating();
    int start;
    io_data_t p;
    start = errors;
    @(posedge clk_28mhz);
    covox_en <= 1'b0;
    for (int i = 0; i < 5; i++) begin
      write_random(cvx_port(i), 1);
    end
    wait_result();
    check_samples();
    @(posedge clk_28mhz);
    covox_en <= 1'b1;
    repeat (6) begin
      do p = rand_byte(); while (is_listed(p));
      write_random(p, 1);
    end
    wait_result();
    check_samples();
    check_val("tape_out", int'(fe_m[3]), int'(tape_out));
    // held writes
    write_random(port_cvx_fb, 5);
    write_random(port_cvx_c, 5);
    write_random(port_fe, 5);
    wait_result();
    check_samples();
    check_val("tape_out", int'(fe_m[3]), int'(tape_out));
    end_test("gating", start);
  endtask

  task automatic tape_input();
    int start;
    io_data_t v;
    start = errors;
    v = rand_byte();
    v[4] = 1'b1;
    write_port(port_fe, v, 1);
    apply_model(port_fe, v);
    wait_result();
    check_samples();
    @(posedge clk_28mhz);
    tape_in <= 1'b1;
    @(posedge clk_28mhz);
    @(negedge clk_28mhz);
    check_samples();
    @(posedge clk_28mhz);
    tape_in <= 1'b0;
    @(posedge clk_28mhz);
    @(negedge clk_28mhz);
    check_samples();
    end_test("tape_in", start);
  endtask

  initial begin
    rst      = 1'b1;
    iorq     = 1'b0;
    wr       = 1'b0;
    addr     = '0;
    data     = '0;
    covox_en = 1'b0;
    tape_in  = 1'b0;
    fe_m     = '0;
    for (int i = 0; i < 5; i++) begin
      cvx_m[i] = '0;
    end
    repeat (16) @(posedge clk_28mhz);
    rst <= 1'b0;
    reset_state();
    fe_port_writes();
    covox_channels();
    covox_gating();
    tape_input();
    $display("%0d tests, %0d with errors, %0d check errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* spectrum_sound_chk.sv */
`timescale 1ns/1ps

module spectrum_sound_chk (
  input logic                            clk_28mhz,
  input logic                            rst,
  input logic                            covox_en,
  input logic                            tape_out,
  input logic                            fe_wr,
  input logic [sound_pkg::cvx_ports-1:0] cvx_wr
);

  // #fe comes out of reset cleared
  tape_after_reset: assert property (@(posedge clk_28mhz) rst |=> !tape_out)
    else $error("tape_out high in the cycle after reset");

  fe_wr_single: assert property (@(posedge clk_28mhz) disable iff (rst) fe_wr |=> !fe_wr)
    else $error("fe_wr high on two consecutive edges");

  // switch sampled on the edge that builds the strobes
  cvx_gated: assert property (
    @(posedge clk_28mhz) disable iff (rst) !covox_en |=> (cvx_wr == '0)
  ) else $error("covox strobe raised while covox_en was low");

endmodule

bind spectrum_sound spectrum_sound_chk u_chk (
  .clk_28mhz (clk_28mhz),
  .rst       (rst),
  .covox_en  (covox_en),
  .tape_out  (tape_out),
  .fe_wr     (fe_wr),
  .cvx_wr    (cvx_wr)
);

/* spectrum_sound.sv */
`timescale 1ns/1ps

module spectrum_sound #(
  parameter int beep_level = 4096,
  parameter int tape_level = 2048
) (
  input  logic                clk_28mhz,
  input  logic                rst,
  input  logic                iorq,
  input  logic                wr,
  input  sound_pkg::io_addr_t addr,
  input  sound_pkg::io_data_t data,
  input  logic                covox_en,
  input  logic                tape_in,
  output logic                tape_out,
  output sound_pkg::sample_t  audio_l,
  output sound_pkg::sample_t  audio_r
);
  import sound_pkg::*;

  logic                 fe_wr;
  logic [cvx_ports-1:0] cvx_wr;
  io_data_t             wdata;
  logic                 beeper;
  io_data_t             cvx_a;
  io_data_t             cvx_b;
  io_data_t             cvx_c;
  io_data_t             cvx_d;
  io_data_t             cvx_fb;

  // bus writes to port strobes
  io_decode u_decode (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .iorq      (iorq),
    .wr        (wr),
    .addr      (addr),
    .data      (data),
    .covox_en  (covox_en),
    .fe_wr     (fe_wr),
    .cvx_wr    (cvx_wr),
    .wdata     (wdata)
  );

  sound_regs u_regs (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .fe_wr     (fe_wr),
    .cvx_wr    (cvx_wr),
    .wdata     (wdata),
    .tape_out  (tape_out),
    .beeper    (beeper),
    .cvx_a     (cvx_a),
    .cvx_b     (cvx_b),
    .cvx_c     (cvx_c),
    .cvx_d     (cvx_d),
    .cvx_fb    (cvx_fb)
  );

  audio_mixer #(
    .beep_level (beep_level),
    .tape_level (tape_level)
  ) u_mixer (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .beeper    (beeper),
    .tape_in   (tape_in),
    .cvx_a     (cvx_a),
    .cvx_b     (cvx_b),
    .cvx_c     (cvx_c),
    .cvx_d     (cvx_d),
    .cvx_fb    (cvx_fb),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

endmodule

/* audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer #(
  parameter int beep_level = 4096,
  parameter int tape_level = 2048
) (
  input  logic                clk_28mhz,
  input  logic                rst,
  input  logic                beeper,
  input  logic                tape_in,
  input  sound_pkg::io_data_t cvx_a,
  input  sound_pkg::io_data_t cvx_b,
  input  sound_pkg::io_data_t cvx_c,
  input  sound_pkg::io_data_t cvx_d,
  input  sound_pkg::io_data_t cvx_fb,
  output sound_pkg::sample_t  audio_l,
  output sound_pkg::sample_t  audio_r
);
  import sound_pkg::*;

  sample_t cvx_l;
  sample_t cvx_r;
  sample_t beep_term;
  sample_t tape_term;
  sample_t mix_l;
  sample_t mix_r;

  // mono covox goes to both sides
  always_comb begin
    cvx_l = (sample_t'(cvx_a) + sample_t'(cvx_b) + sample_t'(cvx_fb)) << cvx_shift;
    cvx_r = (sample_t'(cvx_c) + sample_t'(cvx_d) + sample_t'(cvx_fb)) << cvx_shift;
  end

  // beeper and tape are flat offsets, centred
  always_comb begin
    beep_term = beeper  ? sample_t'(beep_level) : '0;
    tape_term = tape_in ? sample_t'(tape_level) : '0;
    mix_l     = cvx_l + beep_term + tape_term;
    mix_r     = cvx_r + beep_term + tape_term;
  end

  // worst case 30624, no clipping needed
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_l <= '0;
      audio_r <= '0;
    end else begin
      audio_l <= mix_l;
      audio_r <= mix_r;
    end
  end

endmodule

/* sound_regs.sv */
`timescale 1ns/1ps

module sound_regs (
  input  logic                            clk_28mhz,
  input  logic                            rst,
  input  logic                            fe_wr,
  input  logic [sound_pkg::cvx_ports-1:0] cvx_wr,
  input  sound_pkg::io_data_t             wdata,
  output logic                            tape_out,
  output logic                            beeper,
  output sound_pkg::io_data_t             cvx_a,
  output sound_pkg::io_data_t             cvx_b,
  output sound_pkg::io_data_t             cvx_c,
  output sound_pkg::io_data_t             cvx_d,
  output sound_pkg::io_data_t             cvx_fb
);
  import sound_pkg::*;

  // #fe bit positions, the low bits are border colour
  localparam int fe_tape_bit = 3;
  localparam int fe_beep_bit = 4;

  io_data_t fe_q;
  io_data_t cvx_q [cvx_ports];

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_q <= '0;
    end else if (fe_wr) begin
      fe_q <= wdata;
    end
  end

  // one byte per covox strobe
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      for (int i = 0; i < cvx_ports; i++) begin
        cvx_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < cvx_ports; i++) begin
        if (cvx_wr[i]) begin
          cvx_q[i] <= wdata;
        end
      end
    end
  end

  assign tape_out = fe_q[fe_tape_bit];
  assign beeper   = fe_q[fe_beep_bit];

  assign cvx_a  = cvx_q[cvx_idx_a];
  assign cvx_b  = cvx_q[cvx_idx_b];
  assign cvx_c  = cvx_q[cvx_idx_c];
  assign cvx_d  = cvx_q[cvx_idx_d];
  assign cvx_fb = cvx_q[cvx_idx_fb];

endmodule

/* io_decode.sv */
`timescale 1ns/1ps

module io_decode (
  input  logic                            clk_28mhz,
  input  logic                            rst,
  input  logic                            iorq,
  input  logic                            wr,
  input  sound_pkg::io_addr_t             addr,
  input  sound_pkg::io_data_t             data,
  input  logic                            covox_en,
  output logic                            fe_wr,
  output logic [sound_pkg::cvx_ports-1:0] cvx_wr,
  output sound_pkg::io_data_t             wdata
);
  import sound_pkg::*;

  logic                 wr_lvl_q;
  logic                 wr_lvl_qq;
  io_data_t             port_q;
  io_data_t             data_q;
  logic                 wr_start;
  logic [cvx_ports-1:0] cvx_hit;

  // iorq and wr as one level, delayed twice for the edge detect
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      wr_lvl_q  <= 1'b0;
      wr_lvl_qq <= 1'b0;
    end else begin
      wr_lvl_q  <= iorq & wr;
      wr_lvl_qq <= wr_lvl_q;
    end
  end

  // address and data as seen on the first edge of the write
  always_ff @(posedge clk_28mhz) begin
    port_q <= addr[7:0];
    data_q <= data;
  end

  // a long write still gives only one start
  assign wr_start = wr_lvl_q & ~wr_lvl_qq;

  always_comb begin
    cvx_hit             = '0;
    cvx_hit[cvx_idx_a]  = (port_q == port_cvx_a);
    cvx_hit[cvx_idx_b]  = (port_q == port_cvx_b);
    cvx_hit[cvx_idx_c]  = (port_q == port_cvx_c);
    cvx_hit[cvx_idx_d]  = (port_q == port_cvx_d);
    cvx_hit[cvx_idx_fb] = (port_q == port_cvx_fb);
  end

  // one-cycle strobes, covox ports only while the switch is on
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_wr  <= 1'b0;
      cvx_wr <= '0;
    end else begin
      fe_wr  <= wr_start && (port_q == port_fe);
      cvx_wr <= (wr_start && covox_en) ? cvx_hit : '0;
    end
  end

  always_ff @(posedge clk_28mhz) begin
    if (wr_start) begin
      wdata <= data_q;
    end
  end

endmodule

/* sound_pkg.sv */
package sound_pkg;

  // cpu i/o bus, only the low address byte is decoded
  typedef logic [15:0] io_addr_t;
  typedef logic [7:0]  io_data_t;

  // unsigned pcm sample on both outputs
  typedef logic [15:0] sample_t;

  // port #fe, beeper and tape out
  localparam io_data_t port_fe     = 8'hFE;

  // soundrive channels
  localparam io_data_t port_cvx_a  = 8'h0F;
  localparam io_data_t port_cvx_b  = 8'h1F;
  localparam io_data_t port_cvx_c  = 8'h4F;
  localparam io_data_t port_cvx_d  = 8'h5F;

  // mono covox, heard on both sides
  localparam io_data_t port_cvx_fb = 8'hFB;

  // covox strobe vector layout
  localparam int cvx_ports  = 5;
  localparam int cvx_idx_a  = 0;
  localparam int cvx_idx_b  = 1;
  localparam int cvx_idx_c  = 2;
  localparam int cvx_idx_d  = 3;
  localparam int cvx_idx_fb = 4;

  // three channel bytes per side, scaled up into the 16-bit range
  localparam int cvx_shift  = 5;

endpackage
